// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = exu_tb
FILE_LIST = tb.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import exu_pkg::*; (
  input  alu_op_t         op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] y
);

  logic [4:0] shamt;
  logic       signed_lt;
  logic       unsigned_lt;
  logic       equal;
  logic       cmp;
  logic       is_cmp;

  assign shamt       = b[4:0];
  assign signed_lt   = $signed(a) < $signed(b);
  assign unsigned_lt = a < b;
  assign equal       = a == b;

  // compare ops share one result path
  always_comb begin
    is_cmp = 1'b1;
    cmp    = 1'b0;
    case (op)
      alu_slt,
      alu_lt:   cmp = signed_lt;
      alu_sltu,
      alu_ltu:  cmp = unsigned_lt;
      alu_eq:   cmp = equal;
      alu_ne:   cmp = !equal;
      alu_ge:   cmp = !signed_lt;
      alu_geu:  cmp = !unsigned_lt;
      default:  is_cmp = 1'b0;
    endcase
  end

  always_comb begin
    if (is_cmp) begin
      y = {{(xlen-1){1'b0}}, cmp};
    end else begin
      case (op)
        alu_add:    y = a + b;
        alu_sub:    y = a - b;
        alu_and:    y = a & b;
        alu_or:     y = a | b;
        alu_xor:    y = a ^ b;
        alu_sll:    y = a << shamt;
        alu_srl:    y = a >> shamt;
        alu_sra:    y = $unsigned($signed(a) >>> shamt);
        alu_copy_b: y = b;
        default:    y = '0;
      endcase
    end
  end

endmodule

// File: logic/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import exu_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            load,
  input  decode_bundle_t  decode,
  input  logic [xlen-1:0] op1,
  input  logic [xlen-1:0] op2,
  input  logic [xlen-1:0] store_data,
  input  logic [xlen-1:0] csr_source,
  input  logic [xlen-1:0] alu_y,
  output alu_op_t         alu_op,
  output logic [xlen-1:0] alu_a,
  output logic [xlen-1:0] alu_b,
  output exec_result_t    result_fields,
  output logic [xlen-1:0] wdata,
  output logic [xlen-1:0] csr_wdata,
  output logic            is_redirect,
  output logic            is_fence
);

  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] snpc_q;
  logic [xlen-1:0] dnpc_q;
  logic [xlen-1:0] store_data_q;
  logic [xlen-1:0] csr_source_q;
  npc_sel_t        npc_sel_q;
  wb_sel_t         wb_sel_q;
  logic [xlen-1:0] npc;

  // flags of the incoming instruction, latched as state by flush_control
  assign is_redirect = decode.npc_sel != npc_seq;
  assign is_fence    = decode.fence_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      npc_sel_q <= npc_seq;
      wb_sel_q  <= wb_alu;
    end else if (load) begin
      npc_sel_q <= decode.npc_sel;
      wb_sel_q  <= decode.wb_sel;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      alu_op       <= decode.alu_op;
      alu_a        <= op1;
      alu_b        <= op2;
      pc_q         <= decode.pc;
      snpc_q       <= decode.pc + 32'd4;
      dnpc_q       <= decode.pc + decode.imm;
      store_data_q <= store_data;
      csr_source_q <= csr_source;
      // result of the instruction leaving the stage
      csr_wdata    <= alu_y;
    end
  end

  always_comb begin
    case (npc_sel_q)
      npc_jal:    npc = dnpc_q;
      npc_jalr:   npc = {alu_y[xlen-1:1], 1'b0};
      npc_branch: npc = alu_y[0] ? dnpc_q : snpc_q;
      default:    npc = snpc_q;
    endcase
  end

  always_comb begin
    case (wb_sel_q)
      wb_snpc: wdata = snpc_q;
      wb_dnpc: wdata = dnpc_q;
      wb_csr:  wdata = csr_source_q;
      default: wdata = alu_y;
    endcase
  end

  // valid is filled in from the stage state
  always_comb begin
    result_fields.valid      = 1'b0;
    result_fields.pc         = pc_q;
    result_fields.npc        = npc;
    result_fields.snpc       = snpc_q;
    result_fields.wdata      = wdata;
    result_fields.store_data = store_data_q;
    result_fields.csr_wdata  = csr_wdata;
  end

endmodule

// File: logic/exu_pkg.sv
package exu_pkg;

  localparam int xlen = 32;
  localparam int count_width = 64;

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu,
    alu_copy_b
  } alu_op_t;

  typedef enum logic [1:0] {
    op1_src1,
    op1_forward,
    op1_last_wb,
    op1_pc
  } op1_sel_t;

  typedef enum logic [2:0] {
    op2_src2,
    op2_imm,
    op2_forward,
    op2_last_wb,
    op2_csr
  } op2_sel_t;

  typedef enum logic [1:0] {
    csr_ext,
    csr_last_result,
    csr_last_wdata
  } csr_sel_t;

  typedef enum logic [1:0] {
    npc_seq,
    npc_jal,
    npc_jalr,
    npc_branch
  } npc_sel_t;

  typedef enum logic [1:0] {
    wb_alu,
    wb_snpc,
    wb_dnpc,
    wb_csr
  } wb_sel_t;

  typedef enum logic [1:0] {
    st_empty,
    st_valid,
    st_redirect,
    st_fence
  } exu_state_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] csr_src;
    alu_op_t         alu_op;
    op1_sel_t        op1_sel;
    op2_sel_t        op2_sel;
    csr_sel_t        csr_sel;
    npc_sel_t        npc_sel;
    wb_sel_t         wb_sel;
    logic            fence_i;
  } decode_bundle_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] npc;
    logic [xlen-1:0] snpc;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] store_data;
    logic [xlen-1:0] csr_wdata;
  } exec_result_t;

  typedef struct packed {
    logic [count_width-1:0] cycles;
    logic [count_width-1:0] retired;
  } perf_counts_t;

endpackage

// File: logic/exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            decode_valid,
  input  decode_bundle_t  decode,
  input  logic [xlen-1:0] forward_data,
  input  logic            block,
  input  logic            exception,
  output exec_result_t    result,
  output logic            clear_pipeline,
  output logic            clear_cache,
  output perf_counts_t    counts
);

  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [xlen-1:0] store_data;
  logic [xlen-1:0] csr_source;
  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  logic [xlen-1:0] alu_y;
  logic [xlen-1:0] wdata;
  logic [xlen-1:0] csr_wdata;
  alu_op_t         alu_op;
  exec_result_t    result_fields;
  exu_state_t      state;
  logic            load;
  logic            is_redirect;
  logic            is_fence;
  logic            retire;

  operand_select i_operand_select (
    .decode         (decode),
    .forward_data   (forward_data),
    .last_wdata     (wdata),
    .last_result    (alu_y),
    .last_csr_wdata (csr_wdata),
    .op1            (op1),
    .op2            (op2),
    .store_data     (store_data),
    .csr_source     (csr_source)
  );

  exec_stage i_exec_stage (
    .clock         (clock),
    .reset         (reset),
    .load          (load),
    .decode        (decode),
    .op1           (op1),
    .op2           (op2),
    .store_data    (store_data),
    .csr_source    (csr_source),
    .alu_y         (alu_y),
    .alu_op        (alu_op),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .result_fields (result_fields),
    .wdata         (wdata),
    .csr_wdata     (csr_wdata),
    .is_redirect   (is_redirect),
    .is_fence      (is_fence)
  );

  alu i_alu (
    .op (alu_op),
    .a  (alu_a),
    .b  (alu_b),
    .y  (alu_y)
  );

  flush_control i_flush_control (
    .clock          (clock),
    .reset          (reset),
    .decode_valid   (decode_valid),
    .fence_i        (is_fence),
    .redirect_next  (is_redirect),
    .block          (block),
    .exception      (exception),
    .state          (state),
    .load           (load),
    .clear_pipeline (clear_pipeline),
    .clear_cache    (clear_cache),
    .retire         (retire)
  );

  retire_counter i_retire_counter (
    .clock  (clock),
    .reset  (reset),
    .block  (block),
    .retire (retire),
    .counts (counts)
  );

  always_comb begin
    result       = result_fields;
    result.valid = state != st_empty;
  end

endmodule

// File: logic/flush_control.sv
`timescale 1ns/1ps

module flush_control import exu_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       decode_valid,
  input  logic       fence_i,
  input  logic       redirect_next,
  input  logic       block,
  input  logic       exception,
  output exu_state_t state,
  output logic       load,
  output logic       clear_pipeline,
  output logic       clear_cache,
  output logic       retire
);

  exu_state_t state_next;
  logic       accept;

  assign load   = !block;
  // a decode arriving under a flush is dropped
  assign accept = decode_valid && !exception && !clear_pipeline;

  always_comb begin
    if (!accept) begin
      state_next = st_empty;
    end else if (fence_i) begin
      state_next = st_fence;
    end else if (redirect_next) begin
      state_next = st_redirect;
    end else begin
      state_next = st_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_empty;
    end else if (!block) begin
      state <= state_next;
    end
  end

  // untaken branches flush too
  assign clear_pipeline = (state == st_redirect) || (state == st_fence);
  assign clear_cache    = state == st_fence;
  assign retire         = !block && (state != st_empty);

endmodule

// File: logic/operand_select.sv
`timescale 1ns/1ps

module operand_select import exu_pkg::*; (
  input  decode_bundle_t  decode,
  input  logic [xlen-1:0] forward_data,
  input  logic [xlen-1:0] last_wdata,
  input  logic [xlen-1:0] last_result,
  input  logic [xlen-1:0] last_csr_wdata,
  output logic [xlen-1:0] op1,
  output logic [xlen-1:0] op2,
  output logic [xlen-1:0] store_data,
  output logic [xlen-1:0] csr_source
);

  // csr read value, possibly bypassed from the instruction ahead
  always_comb begin
    case (decode.csr_sel)
      csr_last_result: csr_source = last_result;
      csr_last_wdata:  csr_source = last_csr_wdata;
      default:         csr_source = decode.csr_src;
    endcase
  end

  always_comb begin
    case (decode.op1_sel)
      op1_forward: op1 = forward_data;
      op1_last_wb: op1 = last_wdata;
      op1_pc:      op1 = decode.pc;
      default:     op1 = decode.src1;
    endcase
  end

  // rs2 after forwarding, also the store data
  always_comb begin
    case (decode.op2_sel)
      op2_forward: store_data = forward_data;
      op2_last_wb: store_data = last_wdata;
      default:     store_data = decode.src2;
    endcase
  end

  always_comb begin
    case (decode.op2_sel)
      op2_imm: op2 = decode.imm;
      op2_csr: op2 = csr_source;
      default: op2 = store_data;
    endcase
  end

endmodule

// File: logic/retire_counter.sv
`timescale 1ns/1ps

module retire_counter import exu_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         block,
  input  logic         retire,
  output perf_counts_t counts
);

  logic [count_width-1:0] cycles_q;
  logic [count_width-1:0] retired_q;

  // mcycle keeps running under block
  always_ff @(posedge clock) begin
    if (reset) begin
      cycles_q <= '0;
    end else begin
      cycles_q <= cycles_q + 1'b1;
    end
  end

  // minstret
  always_ff @(posedge clock) begin
    if (reset) begin
      retired_q <= '0;
    end else if (retire && !block) begin
      retired_q <= retired_q + 1'b1;
    end
  end

  always_comb begin
    counts.cycles  = cycles_q;
    counts.retired = retired_q;
  end

endmodule

// File: tb.f
logic/exu_pkg.sv
logic/alu.sv
logic/operand_select.sv
logic/exec_stage.sv
logic/flush_control.sv
logic/retire_counter.sv
logic/exu_top.sv
tests/exu_checker.sv
tests/exu_tb.sv

// File: tests/exu_checker.sv
`timescale 1ns/1ps

module exu_checker import exu_pkg::*; (
  input logic         clock,
  input logic         reset,
  input logic         block,
  input logic         clear_pipeline,
  input logic         clear_cache,
  input exec_result_t result,
  input perf_counts_t counts
);

  // fence.i is a pipeline flush as well
  cache_implies_pipeline: assert property (
    @(posedge clock) disable iff (reset) clear_cache |-> clear_pipeline
  ) else $error("clear_cache high without clear_pipeline");

  // decode behind a flush gets dropped
  no_valid_after_flush: assert property (
    @(posedge clock) disable iff (reset) clear_pipeline && !block |=> !result.valid
  ) else $error("result valid in the cycle after a flush");

  // mcycle still runs under block, minstret does not
  hold_under_block: assert property (
    @(posedge clock) disable iff (reset)
      block |=> $stable(result) && $stable(counts.retired)
  ) else $error("stage output or retired count moved while block was high");

endmodule

bind exu_top exu_checker i_exu_checker (
  .clock          (clock),
  .reset          (reset),
  .block          (block),
  .clear_pipeline (clear_pipeline),
  .clear_cache    (clear_cache),
  .result         (result),
  .counts         (counts)
);

// File: tests/exu_tb.sv
`timescale 1ns/1ps

module exu_tb import exu_pkg::*; ();

  typedef struct packed {
    decode_bundle_t  decode;
    logic            decode_valid;
    logic            block;
    logic            exception;
    logic [xlen-1:0] forward_data;
    logic            exp_valid;
    logic            exp_clear_pipeline;
    logic            exp_clear_cache;
    logic [xlen-1:0] exp_wdata;
    logic [xlen-1:0] exp_npc;
    logic [xlen-1:0] exp_store;
    logic [xlen-1:0] exp_pc;
    logic [xlen-1:0] exp_csr_wdata;
    logic [31:0]     exp_retired;
  } row_t;

  logic            clock;
  logic            reset;
  logic            decode_valid;
  decode_bundle_t  decode;
  logic [xlen-1:0] forward_data;
  logic            block;
  logic            exception;
  exec_result_t    result;
  logic            clear_pipeline;
  logic            clear_cache;
  perf_counts_t    counts;

  row_t rows[$];
  int   accepted_total;
  int   current_row;
  int   cycle_count;
  int   timeout_limit;

  exu_top i_exu_top (
    .clock          (clock),
    .reset          (reset),
    .decode_valid   (decode_valid),
    .decode         (decode),
    .forward_data   (forward_data),
    .block          (block),
    .exception      (exception),
    .result         (result),
    .clear_pipeline (clear_pipeline),
    .clear_cache    (clear_cache),
    .counts         (counts)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > timeout_limit) begin
      $display("timeout after %0d cycles, the table did not finish", cycle_count);
      $display("Testbench failed");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] row %0d %s: got 0x%0h, expected 0x%0h",
               current_row, name, actual, expected);
      $display("Testbench failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // rv32i semantics, compares return their truth in bit 0
  function automatic logic [xlen-1:0] alu_model(alu_op_t op, logic [xlen-1:0] a,
                                                logic [xlen-1:0] b);
    int          sa;
    int          sb;
    logic [63:0] ext;
    logic [63:0] shifted;
    logic [31:0] r;
    sa = a;
    sb = b;
    ext = {{32{a[31]}}, a};
    shifted = ext >> b[4:0];
    r = '0;
    case (op)
      alu_add:    r = a + b;
      alu_sub:    r = a + ~b + 32'd1;
      alu_and:    r = a & b;
      alu_or:     r = a | b;
      alu_xor:    r = a ^ b;
      alu_sll:    r = a << b[4:0];
      alu_srl:    r = a >> b[4:0];
      alu_sra:    r = shifted[31:0];
      alu_slt,
      alu_lt:     r = {31'b0, sa < sb};
      alu_ge:     r = {31'b0, sa >= sb};
      alu_sltu,
      alu_ltu:    r = {31'b0, a < b};
      alu_geu:    r = {31'b0, a >= b};
      alu_eq:     r = {31'b0, a == b};
      alu_ne:     r = {31'b0, a != b};
      alu_copy_b: r = b;
      default:    r = '0;
    endcase
    return r;
  endfunction

  function automatic decode_bundle_t new_decode(alu_op_t op, op1_sel_t sel1, op2_sel_t sel2,
                                                npc_sel_t npc_sel, wb_sel_t wb_sel);
    decode_bundle_t d;
    d.pc      = $urandom & 32'hffff_fffc;
    d.imm     = $urandom;
    d.src1    = $urandom;
    d.src2    = $urandom;
    d.csr_src = $urandom;
    d.alu_op  = op;
    d.op1_sel = sel1;
    d.op2_sel = sel2;
    d.csr_sel = csr_ext;
    d.npc_sel = npc_sel;
    d.wb_sel  = wb_sel;
    d.fence_i = 1'b0;
    return d;
  endfunction

  function automatic decode_bundle_t random_add();
    return new_decode(alu_add, op1_src1, op2_src2, npc_seq, wb_alu);
  endfunction

  task automatic add_row(input decode_bundle_t d, input logic valid_in, input logic block_in,
                         input logic exception_in, input logic [xlen-1:0] forward_in);
    row_t r;
    r = '0;
    r.decode       = d;
    r.decode_valid = valid_in;
    r.block        = block_in;
    r.exception    = exception_in;
    r.forward_data = forward_in;
    rows.push_back(r);
  endtask

  task automatic build_table();
    decode_bundle_t d;
    alu_op_t        op;
    op = op.first();
    do begin
      add_row(new_decode(op, op1_src1, op2_src2, npc_seq, wb_alu), 1'b1, 1'b0, 1'b0, '0);
      op = op.next();
    end while (op != op.first());
    d = new_decode(alu_eq, op1_src1, op2_src2, npc_seq, wb_alu);
    d.src2 = d.src1;
    add_row(d, 1'b1, 1'b0, 1'b0, '0);
    // operands that differ between signed and unsigned order
    d = new_decode(alu_slt, op1_src1, op2_src2, npc_seq, wb_alu);
    d.src1 = 32'h8000_0010;
    d.src2 = 32'h0000_0005;
    add_row(d, 1'b1, 1'b0, 1'b0, '0);
    d.alu_op = alu_sltu;
    add_row(d, 1'b1, 1'b0, 1'b0, '0);
    add_row(new_decode(alu_add, op1_src1, op2_imm, npc_seq, wb_alu), 1'b1, 1'b0, 1'b0, '0);
    add_row(new_decode(alu_sra, op1_src1, op2_imm, npc_seq, wb_alu), 1'b1, 1'b0, 1'b0, '0);
    // bypass from the held result and from later stages
    add_row(new_decode(alu_add, op1_last_wb, op2_src2, npc_seq, wb_alu), 1'b1, 1'b0, 1'b0, '0);
    add_row(new_decode(alu_sub, op1_src1, op2_last_wb, npc_seq, wb_alu), 1'b1, 1'b0, 1'b0, '0);
    add_row(new_decode(alu_xor, op1_forward, op2_src2, npc_seq, wb_alu), 1'b1, 1'b0, 1'b0,
            $urandom);
    add_row(new_decode(alu_or, op1_src1, op2_forward, npc_seq, wb_alu), 1'b1, 1'b0, 1'b0,
            $urandom);
    add_row(new_decode(alu_copy_b, op1_src1, op2_csr, npc_seq, wb_alu), 1'b1, 1'b0, 1'b0, '0);
    add_row(new_decode(alu_add, op1_src1, op2_src2, npc_seq, wb_csr), 1'b1, 1'b0, 1'b0, '0);
    d = new_decode(alu_copy_b, op1_src1, op2_csr, npc_seq, wb_alu);
    d.csr_sel = csr_last_result;
    add_row(d, 1'b1, 1'b0, 1'b0, '0);
    d.csr_sel = csr_last_wdata;
    add_row(d, 1'b1, 1'b0, 1'b0, '0);
    // jal, then a decode dropped under the flush
    add_row(new_decode(alu_add, op1_pc, op2_imm, npc_jal, wb_snpc), 1'b1, 1'b0, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b0, 1'b0, '0);
    d = new_decode(alu_add, op1_src1, op2_imm, npc_jalr, wb_snpc);
    d.src1 = d.src1 & 32'hffff_fffe;
    d.imm  = d.imm | 32'h1;
    add_row(d, 1'b1, 1'b0, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b0, 1'b0, '0);
    // taken beq, untaken bne, taken blt
    d = new_decode(alu_eq, op1_src1, op2_src2, npc_branch, wb_alu);
    d.src2 = d.src1;
    add_row(d, 1'b1, 1'b0, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b0, 1'b0, '0);
    d.alu_op = alu_ne;
    add_row(d, 1'b1, 1'b0, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b0, 1'b0, '0);
    d = new_decode(alu_lt, op1_src1, op2_src2, npc_branch, wb_alu);
    d.src1 = 32'hffff_fff0;
    d.src2 = 32'h0000_0010;
    add_row(d, 1'b1, 1'b0, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b0, 1'b0, '0);
    d = random_add();
    d.fence_i = 1'b1;
    add_row(d, 1'b1, 1'b0, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b0, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b0, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b0, 1'b1, '0);
    add_row(random_add(), 1'b0, 1'b0, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b0, 1'b0, '0);
    // stalls, the second one over a pending redirect
    add_row(random_add(), 1'b1, 1'b1, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b1, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b0, 1'b0, '0);
    add_row(new_decode(alu_add, op1_pc, op2_imm, npc_jal, wb_snpc), 1'b1, 1'b0, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b1, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b0, 1'b0, '0);
    add_row(random_add(), 1'b1, 1'b0, 1'b0, '0);
  endtask

  // walks the table through the stage rules, block rows keep what is held
  task automatic compute_expected();
    row_t            r;
    logic [xlen-1:0] last_wdata;
    logic [xlen-1:0] last_alu;
    logic [xlen-1:0] last_csr;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] store;
    logic [xlen-1:0] csr;
    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] npc;
    logic [xlen-1:0] held_pc;
    logic            held_valid;
    logic            held_flush;
    logic            held_fence;
    logic            accept;
    int              retired;
    last_wdata = '0;
    last_alu = '0;
    last_csr = '0;
    store = '0;
    npc = '0;
    held_pc = '0;
    held_valid = 1'b0;
    held_flush = 1'b0;
    held_fence = 1'b0;
    retired = 0;
    accepted_total = 0;
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      if (!r.block) begin
        if (held_valid) retired++;
        accept = r.decode_valid && !r.exception && !held_flush;
        if (r.decode.csr_sel == csr_last_result) csr = last_alu;
        else if (r.decode.csr_sel == csr_last_wdata) csr = last_csr;
        else csr = r.decode.csr_src;
        if (r.decode.op1_sel == op1_forward) op1 = r.forward_data;
        else if (r.decode.op1_sel == op1_last_wb) op1 = last_wdata;
        else if (r.decode.op1_sel == op1_pc) op1 = r.decode.pc;
        else op1 = r.decode.src1;
        if (r.decode.op2_sel == op2_forward) store = r.forward_data;
        else if (r.decode.op2_sel == op2_last_wb) store = last_wdata;
        else store = r.decode.src2;
        if (r.decode.op2_sel == op2_imm) op2 = r.decode.imm;
        else if (r.decode.op2_sel == op2_csr) op2 = csr;
        else op2 = store;
        alu_y = alu_model(r.decode.alu_op, op1, op2);
        case (r.decode.npc_sel)
          npc_jal:    npc = r.decode.pc + r.decode.imm;
          npc_jalr:   npc = alu_y & 32'hffff_fffe;
          npc_branch: npc = alu_y[0] ? r.decode.pc + r.decode.imm : r.decode.pc + 32'd4;
          default:    npc = r.decode.pc + 32'd4;
        endcase
        last_csr = last_alu;
        last_alu = alu_y;
        case (r.decode.wb_sel)
          wb_snpc: last_wdata = r.decode.pc + 32'd4;
          wb_dnpc: last_wdata = r.decode.pc + r.decode.imm;
          wb_csr:  last_wdata = csr;
          default: last_wdata = alu_y;
        endcase
        held_pc = r.decode.pc;
        held_valid = accept;
        held_flush = accept && (r.decode.fence_i || r.decode.npc_sel != npc_seq);
        held_fence = accept && r.decode.fence_i;
        if (accept) accepted_total++;
      end
      r.exp_valid          = held_valid;
      r.exp_clear_pipeline = held_flush;
      r.exp_clear_cache    = held_fence;
      r.exp_wdata          = last_wdata;
      r.exp_npc            = npc;
      r.exp_store          = store;
      r.exp_pc             = held_pc;
      r.exp_csr_wdata      = last_csr;
      r.exp_retired        = retired;
      rows[i] = r;
    end
  endtask

  task automatic apply_row(input int i);
    decode       = rows[i].decode;
    decode_valid = rows[i].decode_valid;
    block        = rows[i].block;
    exception    = rows[i].exception;
    forward_data = rows[i].forward_data;
  endtask

  task automatic check_row(input int i);
    row_t r;
    r = rows[i];
    current_row = i;
    check_value("result.valid", 64'(result.valid), 64'(r.exp_valid));
    check_value("clear_pipeline", 64'(clear_pipeline), 64'(r.exp_clear_pipeline));
    check_value("clear_cache", 64'(clear_cache), 64'(r.exp_clear_cache));
    check_value("counts.retired", counts.retired, 64'(r.exp_retired));
    // one cycle of idle decode sits between reset and row 0
    check_value("counts.cycles", counts.cycles, 64'(i + 2));
    if (r.exp_valid) begin
      check_value("result.wdata", 64'(result.wdata), 64'(r.exp_wdata));
      check_value("result.npc", 64'(result.npc), 64'(r.exp_npc));
      check_value("result.store_data", 64'(result.store_data), 64'(r.exp_store));
      check_value("result.pc", 64'(result.pc), 64'(r.exp_pc));
      check_value("result.snpc", 64'(result.snpc), 64'(r.exp_pc + 32'd4));
      check_value("result.csr_wdata", 64'(result.csr_wdata), 64'(r.exp_csr_wdata));
    end
  endtask

  initial begin
    void'($urandom(32));
    clock = 1'b0;
    reset = 1'b1;
    decode_valid = 1'b0;
    decode = '0;
    forward_data = '0;
    block = 1'b0;
    exception = 1'b0;
    current_row = -1;
    build_table();
    compute_expected();
    timeout_limit = rows.size() * 4 + 50;
    repeat (10) @(posedge clock);
    #1;
    check_value("result.valid", 64'(result.valid), 64'd0);
    check_value("clear_pipeline", 64'(clear_pipeline), 64'd0);
    check_value("clear_cache", 64'(clear_cache), 64'd0);
    check_value("counts.cycles", counts.cycles, 64'd0);
    check_value("counts.retired", counts.retired, 64'd0);
    reset = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clock);
      #1;
      if (i > 0) check_row(i - 1);
      apply_row(i);
    end
    @(posedge clock);
    #1;
    check_row(rows.size() - 1);
    decode_valid = 1'b0;
    block = 1'b0;
    exception = 1'b0;
    // last held instruction retires here
    @(posedge clock);
    #1;
    current_row = rows.size();
    check_value("result.valid", 64'(result.valid), 64'd0);
    check_value("counts.retired", counts.retired, 64'(accepted_total));
    $display("Testbench passed");
    $finish;
  end

endmodule
